// File: include/sifh_cfg.svh
`ifndef SIFH_CFG_SVH
`define SIFH_CFG_SVH

// timestamp word from the TDC
`define NP 12

// bin index width, one histogram holds 2**NB bins
`define NB 4

// width of one bin count
`define PEAK_MAX 8

// stamps accepted per pass
`define SAMPLES_PER_PASS 32

`define BIN_NUM (1 << `NB)

`endif

// File: rtl/sifhTypesPkg.sv
`include "sifh_cfg.svh"

package sifhTypesPkg;

    typedef logic [`NB-1:0] binT;           // histogram bin index
    typedef logic [`PEAK_MAX-1:0] countT;   // saturating bin count

    // coarse pass reads the top bits as the bin
    typedef struct packed {
        binT bin;
        logic [`NP-`NB-1:0] rest;
    } coarseViewT;

    // fine pass splits the top bits into window and fine bin
    typedef struct packed {
        binT window;
        binT fineBin;
        logic [`NP-2*`NB-1:0] rest;
    } fineViewT;

    // one TDC word, decoded per pass
    typedef union packed {
        coarseViewT coarse;
        fineViewT fine;
    } stampT;

    typedef struct packed {
        logic en;
        binT addr;
        countT data;
    } ramWriteT;

    typedef struct packed {
        binT coarseBin;
        binT fineBin;
        countT peakCount;   // count of the fine peak
    } peakResultT;

endpackage

// File: rtl/sifhCtrlPkg.sv
package sifhCtrlPkg;

    typedef enum logic [2:0] {
        phIdle,
        phClear,    // zero the SRAM
        phBuild,    // accept stamps
        phScan,     // peak search
        phFilter,   // latch coarse window
        phReport
    } phaseT;

    typedef enum logic {
        passCoarse,
        passFine
    } passT;

    // command bundle from the sequencer to the datapath
    typedef struct packed {
        logic clearStart;           // one-cycle pulse
        logic scanStart;            // one-cycle pulse
        passT pass;
        sifhTypesPkg::binT window;  // coarse peak, valid in fine pass
    } seqCmdT;

endpackage

// File: rtl/histRam.sv
`timescale 1ns/1ps
`include "sifh_cfg.svh"

module histRam (
    input  logic                     clk,
    input  sifhTypesPkg::ramWriteT   wr,
    input  sifhTypesPkg::binT        rdAddr,
    output sifhTypesPkg::countT      rdData
);

    sifhTypesPkg::countT mem [`BIN_NUM];

    // write port
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // registered read, returns the old word on a same-address write
    always_ff @(posedge clk) begin
        rdData <= mem[rdAddr];
    end

endmodule

// File: rtl/stampDecode.sv
`timescale 1ns/1ps

module stampDecode (
    input  logic                   clk,
    input  logic                   res,
    input  sifhTypesPkg::stampT    stamp,
    input  logic                   stampValid,
    input  logic                   accept,
    input  sifhCtrlPkg::seqCmdT    cmd,
    output logic                   hit,
    output sifhTypesPkg::binT      hitBin
);

    logic              taken;
    logic              inWindow;
    logic              hitNext;
    sifhTypesPkg::binT binNext;

    assign taken = stampValid && accept;    // stamp seen by the histogram
    assign inWindow = (stamp.fine.window == cmd.window);

    always_comb begin
        if (cmd.pass == sifhCtrlPkg::passCoarse) begin
            hitNext = taken;
            binNext = stamp.coarse.bin;
        end else begin
            // outside the coarse window the stamp is counted but not binned
            hitNext = taken && inWindow;
            binNext = stamp.fine.fineBin;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            hit <= 1'b0;
        end else begin
            hit <= hitNext;
        end
    end

    always_ff @(posedge clk) begin
        hitBin <= binNext;
    end

endmodule

// File: rtl/histBuilder.sv
`timescale 1ns/1ps

module histBuilder (
    input  logic                     clk,
    input  logic                     res,
    input  sifhCtrlPkg::seqCmdT      cmd,
    input  logic                     hit,
    input  sifhTypesPkg::binT        hitBin,
    input  sifhTypesPkg::binT        scanAddr,
    output sifhTypesPkg::countT      scanCount,
    output logic                     clearDone,
    output logic                     busy,
    output sifhTypesPkg::ramWriteT   ramWr,
    output sifhTypesPkg::binT        ramRdAddr,
    input  sifhTypesPkg::countT      ramRdData
);

    logic                   clearing;
    sifhTypesPkg::binT      clrAddr;
    logic                   s1Valid;    // increment waiting for its read data
    sifhTypesPkg::binT      s1Bin;
    sifhTypesPkg::ramWriteT lastWr;     // write of the previous cycle
    sifhTypesPkg::countT    base;
    sifhTypesPkg::countT    incCount;

    // clear counter, one zero write per cycle
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            clearing <= 1'b0;
            clrAddr  <= '0;
        end else if (cmd.clearStart) begin
            clearing <= 1'b1;
            clrAddr  <= '0;
        end else if (clearing) begin
            clrAddr <= clrAddr + 1'b1;
            if (clrAddr == '1) begin
                clearing <= 1'b0;
            end
        end
    end

    assign clearDone = clearing && (clrAddr == '1);

    // increment pipeline, read in cycle 0 and write in cycle 1
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1Valid <= 1'b0;
            lastWr  <= '0;
        end else begin
            s1Valid <= hit;
            lastWr  <= ramWr;
        end
    end

    always_ff @(posedge clk) begin
        s1Bin <= hitBin;
    end

    // the RAM still holds the old count when the last write hit the same bin
    assign base = (lastWr.en && lastWr.addr == s1Bin) ? lastWr.data : ramRdData;
    assign incCount = (base == '1) ? base : base + 1'b1;   // saturate

    always_comb begin
        ramWr = '0;
        if (clearing) begin
            ramWr.en   = 1'b1;
            ramWr.addr = clrAddr;
        end else if (s1Valid) begin
            ramWr.en   = 1'b1;
            ramWr.addr = s1Bin;
            ramWr.data = incCount;
        end
    end

    assign ramRdAddr = hit ? hitBin : scanAddr;    // scan owns the port outside build
    assign scanCount = ramRdData;
    assign busy = hit || s1Valid;

endmodule

// File: rtl/peakFinder.sv
`timescale 1ns/1ps

module peakFinder (
    input  logic                  clk,
    input  logic                  res,
    input  logic                  scanStart,
    output sifhTypesPkg::binT     scanAddr,
    input  sifhTypesPkg::countT   scanCount,
    output logic                  scanDone,
    output sifhTypesPkg::binT     peakBin,
    output sifhTypesPkg::countT   peakCount
);

    logic                active;
    sifhTypesPkg::binT   addr;
    logic                vld;       // scanCount belongs to vldBin
    sifhTypesPkg::binT   vldBin;
    sifhTypesPkg::binT   maxBin;
    sifhTypesPkg::countT maxCount;

    // address sweep over all bins
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            active   <= 1'b0;
            addr     <= '0;
            vld      <= 1'b0;
            scanDone <= 1'b0;
        end else begin
            vld      <= active;
            scanDone <= vld && (vldBin == '1);  // last bin compared
            if (scanStart) begin
                active <= 1'b1;
                addr   <= '0;
            end else if (active) begin
                addr <= addr + 1'b1;
                if (addr == '1) begin
                    active <= 1'b0;
                end
            end
        end
    end

    // address delayed to meet the registered read data
    always_ff @(posedge clk) begin
        vldBin <= addr;
    end

    // running maximum, strictly greater keeps the lowest bin on ties
    always_ff @(posedge clk) begin
        if (scanStart) begin
            maxBin   <= '0;
            maxCount <= '0;
        end else if (vld && scanCount > maxCount) begin
            maxBin   <= vldBin;
            maxCount <= scanCount;
        end
    end

    assign scanAddr = addr;
    assign peakBin = maxBin;
    assign peakCount = maxCount;

endmodule

// File: rtl/histSequencer.sv
`timescale 1ns/1ps
`include "sifh_cfg.svh"

module histSequencer (
    input  logic                      clk,
    input  logic                      res,
    input  logic                      start,
    input  logic                      stampValid,
    output sifhCtrlPkg::seqCmdT       cmd,
    output logic                      accept,
    output logic                      ready,
    input  logic                      clearDone,
    input  logic                      busy,
    input  logic                      scanDone,
    input  sifhTypesPkg::binT         peakBin,
    input  sifhTypesPkg::countT       peakCount,
    output sifhTypesPkg::peakResultT  result,
    output logic                      resultValid
);

    localparam int CntW = $clog2(`SAMPLES_PER_PASS) + 1;

    sifhCtrlPkg::phaseT      phase;
    sifhCtrlPkg::passT       passQ;
    sifhTypesPkg::binT       windowQ;
    logic                    readyQ;
    logic                    clearStartQ;
    logic                    scanStartQ;
    logic [CntW-1:0]         sampleCnt;
    sifhTypesPkg::peakResultT resultQ;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            phase       <= sifhCtrlPkg::phIdle;
            passQ       <= sifhCtrlPkg::passCoarse;
            windowQ     <= '0;
            readyQ      <= 1'b0;
            clearStartQ <= 1'b0;
            scanStartQ  <= 1'b0;
            sampleCnt   <= '0;
        end else begin
            clearStartQ <= 1'b0;
            scanStartQ  <= 1'b0;
            case (phase)
                sifhCtrlPkg::phIdle: begin
                    if (start) begin
                        phase       <= sifhCtrlPkg::phClear;
                        passQ       <= sifhCtrlPkg::passCoarse;
                        clearStartQ <= 1'b1;
                    end
                end
                sifhCtrlPkg::phClear: begin
                    if (clearDone) begin
                        phase     <= sifhCtrlPkg::phBuild;
                        readyQ    <= 1'b1;      // open the TDC
                        sampleCnt <= '0;
                    end
                end
                sifhCtrlPkg::phBuild: begin
                    if (readyQ && stampValid) begin
                        sampleCnt <= sampleCnt + 1'b1;
                        if (sampleCnt == CntW'(`SAMPLES_PER_PASS - 1)) begin
                            readyQ <= 1'b0;
                        end
                    end
                    // wait for the last increment to land in the SRAM
                    if (!readyQ && !busy) begin
                        phase      <= sifhCtrlPkg::phScan;
                        scanStartQ <= 1'b1;
                    end
                end
                sifhCtrlPkg::phScan: begin
                    if (scanDone) begin
                        if (passQ == sifhCtrlPkg::passCoarse) begin
                            phase <= sifhCtrlPkg::phFilter;
                        end else begin
                            phase <= sifhCtrlPkg::phReport;
                        end
                    end
                end
                sifhCtrlPkg::phFilter: begin
                    windowQ     <= peakBin;     // coarse peak becomes the window
                    passQ       <= sifhCtrlPkg::passFine;
                    clearStartQ <= 1'b1;
                    phase       <= sifhCtrlPkg::phClear;
                end
                default: begin
                    phase <= sifhCtrlPkg::phIdle;  // phReport lasts one cycle
                end
            endcase
        end
    end

    // fine peak plus window, held until the next run
    always_ff @(posedge clk) begin
        if (phase == sifhCtrlPkg::phScan && scanDone && passQ == sifhCtrlPkg::passFine) begin
            resultQ.coarseBin <= windowQ;
            resultQ.fineBin   <= peakBin;
            resultQ.peakCount <= peakCount;
        end
    end

    assign cmd.clearStart = clearStartQ;
    assign cmd.scanStart = scanStartQ;
    assign cmd.pass = passQ;
    assign cmd.window = windowQ;

    assign ready = readyQ;
    assign accept = readyQ && (phase == sifhCtrlPkg::phBuild);
    assign result = resultQ;
    assign resultValid = (phase == sifhCtrlPkg::phReport);

endmodule

// File: rtl/siFhTop.sv
`timescale 1ns/1ps

module siFhTop (
    input  logic                      clk,
    input  logic                      res,
    input  logic                      start,
    input  sifhTypesPkg::stampT       stamp,
    input  logic                      stampValid,
    output logic                      ready,
    output sifhTypesPkg::peakResultT  result,
    output logic                      resultValid
);

    sifhCtrlPkg::seqCmdT    cmd;
    logic                   accept;
    logic                   hit;
    sifhTypesPkg::binT      hitBin;
    sifhTypesPkg::binT      scanAddr;
    sifhTypesPkg::countT    scanCount;
    logic                   clearDone;
    logic                   busy;
    logic                   scanDone;
    sifhTypesPkg::binT      peakBin;
    sifhTypesPkg::countT    peakCount;
    sifhTypesPkg::ramWriteT ramWr;
    sifhTypesPkg::binT      ramRdAddr;
    sifhTypesPkg::countT    ramRdData;

    histSequencer iSeq (
        .clk(clk), .res(res), .start(start), .stampValid(stampValid),
        .cmd(cmd), .accept(accept), .ready(ready),
        .clearDone(clearDone), .busy(busy), .scanDone(scanDone),
        .peakBin(peakBin), .peakCount(peakCount),
        .result(result), .resultValid(resultValid)
    );

    stampDecode iDecode (
        .clk(clk), .res(res), .stamp(stamp), .stampValid(stampValid),
        .accept(accept), .cmd(cmd), .hit(hit), .hitBin(hitBin)
    );

    histBuilder iBuilder (
        .clk(clk), .res(res), .cmd(cmd), .hit(hit), .hitBin(hitBin),
        .scanAddr(scanAddr), .scanCount(scanCount),
        .clearDone(clearDone), .busy(busy),
        .ramWr(ramWr), .ramRdAddr(ramRdAddr), .ramRdData(ramRdData)
    );

    peakFinder iPeak (
        .clk(clk), .res(res), .scanStart(cmd.scanStart),
        .scanAddr(scanAddr), .scanCount(scanCount), .scanDone(scanDone),
        .peakBin(peakBin), .peakCount(peakCount)
    );

    histRam iRam (
        .clk(clk), .wr(ramWr), .rdAddr(ramRdAddr), .rdData(ramRdData)
    );

endmodule

// File: verif/siFhTb.sv
`timescale 1ns/1ps
`include "sifh_cfg.svh"

module siFhTb;

    localparam int NumRows = 6;
    localparam int WaitLimit = 1000;    // cycles allowed for any single wait

    typedef struct {
        string             name;
        sifhTypesPkg::binT coarseBias;
        sifhTypesPkg::binT fineBias;
        int unsigned       ratio;       // percent of stamps forced into the bias bins
    } rowT;

    logic                     clk;
    logic                     res;
    logic                     start;
    sifhTypesPkg::stampT      stamp;
    logic                     stampValid;
    logic                     ready;
    sifhTypesPkg::peakResultT result;
    logic                     resultValid;

    integer                   seed;
    rowT                      rows [NumRows];
    sifhTypesPkg::countT      hist [`BIN_NUM];  // reference histogram of the current pass
    sifhTypesPkg::binT        windowRef;        // coarse peak of the model

    siFhTop i_dut (
        .clk(clk),
        .res(res),
        .start(start),
        .stamp(stamp),
        .stampValid(stampValid),
        .ready(ready),
        .result(result),
        .resultValid(resultValid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stopRun();
        $display("tests failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic checkReady(input string testName, input logic expReady,
                              input logic expValid);
        if (ready !== expReady || resultValid !== expValid) begin
            $display("FAILED %s expected ready=%b resultValid=%b actual ready=%b resultValid=%b",
                     testName, expReady, expValid, ready, resultValid);
            stopRun();
        end
    endtask

    task automatic checkResult(input string testName, input sifhTypesPkg::peakResultT exp,
                               input sifhTypesPkg::peakResultT act);
        if (act !== exp) begin
            $write("FAILED %s expected coarse=%h fine=%h count=%0d ",
                   testName, exp.coarseBin, exp.fineBin, exp.peakCount);
            $display("actual coarse=%h fine=%h count=%0d",
                     act.coarseBin, act.fineBin, act.peakCount);
            stopRun();
        end
    endtask

    task automatic timeoutStop(input string testName, input string what);
        $display("timeout in %s: %s", testName, what);
        stopRun();
    endtask

    task automatic clearHist();
        for (int i = 0; i < `BIN_NUM; i++) begin
            hist[i] = '0;
        end
    endtask

    // counts one accepted stamp with saturation
    task automatic addStamp(input sifhTypesPkg::stampT s, input sifhCtrlPkg::passT pass);
        sifhTypesPkg::binT b;
        if (pass == sifhCtrlPkg::passCoarse) begin
            b = s.coarse.bin;
        end else if (s.fine.window == windowRef) begin
            b = s.fine.fineBin;
        end else begin
            return;     // outside the window
        end
        if (hist[b] != '1) begin
            hist[b] = hist[b] + sifhTypesPkg::countT'(1);
        end
    endtask

    // first bin with the strictly highest count
    function automatic sifhTypesPkg::binT highestBin();
        sifhTypesPkg::binT   bin;
        sifhTypesPkg::countT cnt;
        bin = '0;
        cnt = '0;
        for (int i = 0; i < `BIN_NUM; i++) begin
            if (hist[i] > cnt) begin
                bin = sifhTypesPkg::binT'(i);
                cnt = hist[i];
            end
        end
        return bin;
    endfunction

    function automatic sifhTypesPkg::stampT makeStamp(input rowT row);
        sifhTypesPkg::stampT s;
        logic [31:0]         rnd;
        rnd = $random(seed);
        s = rnd[`NP-1:0];
        rnd = $random(seed);
        if (rnd % 100 < row.ratio) begin
            s.fine.window = row.coarseBias;     // same bits as the coarse bin
            s.fine.fineBin = row.fineBias;
        end
        return s;
    endfunction

    // random traffic that must not reach the histogram while ready is low
    task automatic driveIgnored();
        logic [31:0] rnd;
        rnd = $random(seed);
        stampValid = rnd[0];
        stamp = rnd[`NP+1:2];
    endtask

    task automatic waitForReady(input string testName, input string what);
        int cycles;
        cycles = 0;
        while (ready !== 1'b1) begin
            if (cycles == WaitLimit) begin
                timeoutStop(testName, what);
            end
            driveIgnored();
            cycles++;
            @(negedge clk);
        end
        stampValid = 1'b0;
    endtask

    task automatic waitForResult(input string testName);
        int cycles;
        cycles = 0;
        while (resultValid !== 1'b1) begin
            if (cycles == WaitLimit) begin
                timeoutStop(testName, "resultValid never pulsed after the fine pass");
            end
            driveIgnored();
            cycles++;
            @(negedge clk);
        end
        stampValid = 1'b0;
    endtask

    // ready seen at the falling edge is the level the next rising edge samples
    task automatic feedPass(input rowT row, input sifhCtrlPkg::passT pass);
        int                  accepted;
        int                  cycles;
        logic [31:0]         rnd;
        sifhTypesPkg::stampT s;
        accepted = 0;
        cycles = 0;
        while (accepted < `SAMPLES_PER_PASS) begin
            checkReady(row.name, 1'b1, 1'b0);   // no early drop
            if (cycles == WaitLimit) begin
                timeoutStop(row.name, "the pass did not take all its stamps");
            end
            rnd = $random(seed);
            if (rnd[2:0] == 3'd0) begin
                stampValid = 1'b0;      // idle cycle from the TDC
            end else begin
                s = makeStamp(row);
                stamp = s;
                stampValid = 1'b1;
                addStamp(s, pass);
                accepted++;
            end
            cycles++;
            @(negedge clk);
        end
        stampValid = 1'b0;
        checkReady(row.name, 1'b0, 1'b0);       // low right after the last stamp
    endtask

    task automatic runRow(input rowT row);
        sifhTypesPkg::binT        fineBin;
        sifhTypesPkg::peakResultT expected;
        checkReady(row.name, 1'b0, 1'b0);       // idle before start
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        clearHist();
        waitForReady(row.name, "ready did not rise after the coarse clear");
        feedPass(row, sifhCtrlPkg::passCoarse);
        windowRef = highestBin();
        clearHist();
        waitForReady(row.name, "ready did not rise after the fine clear");
        feedPass(row, sifhCtrlPkg::passFine);
        fineBin = highestBin();
        expected.coarseBin = windowRef;
        expected.fineBin = fineBin;
        expected.peakCount = hist[fineBin];
        waitForResult(row.name);
        checkReady(row.name, 1'b0, 1'b1);
        checkResult(row.name, expected, result);
        @(negedge clk);
        checkReady(row.name, 1'b0, 1'b0);       // single-cycle pulse
    endtask

    initial begin
        seed = 32'hdf588ff3;
        rows[0] = '{name: "coarseBias", coarseBias: 4'd5, fineBias: 4'd9, ratio: 50};
        rows[1] = '{name: "uniform", coarseBias: 4'd0, fineBias: 4'd0, ratio: 0};
        rows[2] = '{name: "oneFineBin", coarseBias: 4'd12, fineBias: 4'd3, ratio: 100};
        rows[3] = '{name: "weakBias", coarseBias: 4'd2, fineBias: 4'd14, ratio: 25};
        rows[4] = '{name: "edgeBins", coarseBias: 4'd15, fineBias: 4'd0, ratio: 75};
        rows[5] = '{name: "restart", coarseBias: 4'd5, fineBias: 4'd9, ratio: 50};

        res = 1'b0;
        start = 1'b0;
        stamp = '0;
        stampValid = 1'b0;
        repeat (5) @(negedge clk);
        res = 1'b1;

        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            checkReady("afterReset", 1'b0, 1'b0);
        end

        // later rows rely on the SRAM clear between runs
        for (int r = 0; r < NumRows; r++) begin
            runRow(rows[r]);
            repeat (2) @(negedge clk);
        end

        $display("all tests passed");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+include
rtl/sifhTypesPkg.sv
rtl/sifhCtrlPkg.sv
rtl/histRam.sv
rtl/stampDecode.sv
rtl/histBuilder.sv
rtl/peakFinder.sv
rtl/histSequencer.sv
rtl/siFhTop.sv
verif/siFhTb.sv

// File: run.sh
#!/bin/sh
# builds the coarse/fine histogram testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module siFhTb -f verilog.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/VsiFhTb
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit 1
fi

echo "simulation finished cleanly"
exit 0
